//--- nocRouterPort_macros.svh
`ifndef NOC_ROUTER_PORT_MACROS_SVH
`define NOC_ROUTER_PORT_MACROS_SVH

// payload bits per flit. A head flit carries its hold budget here.
`define PAYLOAD_W 12

// entries in each input FIFO. Must be a power of two.
`define FIFO_DEPTH 16

// input channels on one output port.
`define NUM_PORTS 5

`endif

//--- nocPkg.sv
`include "nocRouterPort_macros.svh"

package nocPkg;

  typedef enum logic [1:0]
  {
    HEAD   = 2'd0,
    BODY   = 2'd1,
    TAIL   = 2'd2,
    SINGLE = 2'd3
  } flitKind_e;

  // round-robin order follows the encoding.
  typedef enum logic [2:0]
  {
    LOCAL = 3'd0,
    NORTH = 3'd1,
    EAST  = 3'd2,
    WEST  = 3'd3,
    SOUTH = 3'd4
  } portId_e;

  // a grant state encodes its channel plus one.
  typedef enum logic [2:0]
  {
    IDLE        = 3'd0,
    GRANT_LOCAL = 3'd1,
    GRANT_NORTH = 3'd2,
    GRANT_EAST  = 3'd3,
    GRANT_WEST  = 3'd4,
    GRANT_SOUTH = 3'd5
  } grantState_e;

  typedef struct packed
  {
    flitKind_e               kind;
    logic [`PAYLOAD_W-1:0] payload;
  } flit_t;

  typedef struct packed
  {
    portId_e src;
    flit_t   flit;
  } outFlit_t;

endpackage

//--- inputFifo.sv
`timescale 1ns/1ps
`include "nocRouterPort_macros.svh"

module inputFifo
(
  input  logic          clk,
  input  logic          rst,
  input  logic          inValid,
  input  nocPkg::flit_t inFlit,
  output logic          inReady,
  output logic          outValid,
  output nocPkg::flit_t outFlit,
  input  logic          pop
);

  localparam int addrW = $clog2(`FIFO_DEPTH);
  localparam int cntW = $clog2(`FIFO_DEPTH + 1);
  localparam logic [cntW-1:0] fullCount = cntW'(`FIFO_DEPTH);

  nocPkg::flit_t    mem [`FIFO_DEPTH];
  logic [addrW-1:0] wrPtr;
  logic [addrW-1:0] rdPtr;
  logic [cntW-1:0]  count;
  logic             wrEn;

  assign inReady = (count != fullCount);
  assign outValid = (count != '0);
  assign outFlit = mem[rdPtr];
  assign wrEn = inValid && inReady;

  always_ff @(posedge clk)
  begin
    if (wrEn)
    begin
      mem[wrPtr] <= inFlit;
    end
  end

  // pointers wrap on their own since the depth is a power of two.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (wrEn)
      begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (pop)
      begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({wrEn, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  noPopWhenEmpty: assert property (@(posedge clk) disable iff (rst) pop |-> outValid);

  // the pointer distance always matches the occupancy, so a write never overruns the head.
  noOverflow: assert property (@(posedge clk) disable iff (rst)
    (count <= fullCount) && (addrW'(wrPtr - rdPtr) == addrW'(count)));

endmodule

//--- holdTimer.sv
`timescale 1ns/1ps
`include "nocRouterPort_macros.svh"

module holdTimer
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  load,
  input  logic [`PAYLOAD_W-1:0] budget,
  input  logic                  step,
  input  logic                  granted,
  output logic                  timesUp
);

  logic [`PAYLOAD_W-1:0] budgetReg;
  logic [`PAYLOAD_W-1:0] budgetNext;
  logic [`PAYLOAD_W-1:0] count;
  logic [`PAYLOAD_W-1:0] countNext;

  // a loaded head counts as the first flit of its own budget.
  always_comb
  begin
    budgetNext = load ? budget : budgetReg;
    if (load)
      countNext = `PAYLOAD_W'(1);
    else if (step)
      countNext = count + 1'b1;
    else
      countNext = count;
  end

  // fires on the flit that uses up the budget, so the arbiter can move on the same edge.
  assign timesUp = step && (countNext == budgetNext);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budgetReg <= '0;
      count <= '0;
    end
    else
    begin
      if (load)
        budgetReg <= budget;
      // an expired window restarts, so a re-grant gets a fresh budget.
      if (!granted || timesUp)
        count <= '0;
      else
        count <= countNext;
    end
  end

  budgetNonZero: assert property (@(posedge clk) disable iff (rst) load |-> (budget != '0));

endmodule

//--- outputArbiter.sv
`timescale 1ns/1ps
`include "nocRouterPort_macros.svh"

module outputArbiter
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NUM_PORTS-1:0] req,
  input  logic                  accepted,
  input  nocPkg::flit_t         acceptedFlit,
  output logic                  grantValid,
  output nocPkg::portId_e       grantPort
);

  nocPkg::grantState_e   state;
  nocPkg::grantState_e   nextState;
  logic [2:0]            holderIdx;
  logic                  isHead;
  logic [`NUM_PORTS-1:0] load;
  logic [`NUM_PORTS-1:0] step;
  logic [`NUM_PORTS-1:0] granted;
  logic [`NUM_PORTS-1:0] timesUp;

  // first requesting channel at or after start, wrapping around.
  function automatic nocPkg::grantState_e pickNext(
    input logic [`NUM_PORTS-1:0] r,
    input int unsigned           start
  );
    logic        found;
    int unsigned idx;
    pickNext = nocPkg::IDLE;
    found = 1'b0;
    for (int k = 0; k < `NUM_PORTS; k++)
    begin
      idx = (start + k) % `NUM_PORTS;
      if (!found && r[idx])
      begin
        found = 1'b1;
        pickNext = nocPkg::grantState_e'(3'(idx + 1));
      end
    end
  endfunction

  assign grantValid = (state != nocPkg::IDLE);
  assign holderIdx = grantValid ? 3'(state - 3'd1) : 3'd0;
  assign grantPort = nocPkg::portId_e'(holderIdx);
  assign isHead = (acceptedFlit.kind == nocPkg::HEAD) || (acceptedFlit.kind == nocPkg::SINGLE);

  always_comb
  begin
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      granted[i] = grantValid && (holderIdx == 3'(i));
      step[i] = granted[i] && accepted;
      load[i] = step[i] && isHead;
    end
  end

  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : genTimer
    holdTimer timer
    (
      .clk     (clk),
      .rst     (rst),
      .load    (load[i]),
      .budget  (acceptedFlit.payload),
      .step    (step[i]),
      .granted (granted[i]),
      .timesUp (timesUp[i])
    );
  end

  // the holder keeps the grant while it requests and has budget left.
  always_comb
  begin
    nextState = state;
    if (state == nocPkg::IDLE)
    begin
      nextState = pickNext(req, 0);
    end
    else if (!req[holderIdx] || timesUp[holderIdx])
    begin
      nextState = pickNext(req, int'(holderIdx) + 1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= nocPkg::IDLE;
    else
      state <= nextState;
  end

  grantHadRequest: assert property (@(posedge clk) disable iff (rst)
    grantValid && $changed(state) |-> |($past(req) & (`NUM_PORTS'(1) << holderIdx)));

  legalState: assert property (@(posedge clk) disable iff (rst)
    state inside {nocPkg::IDLE, nocPkg::GRANT_LOCAL, nocPkg::GRANT_NORTH,
                  nocPkg::GRANT_EAST, nocPkg::GRANT_WEST, nocPkg::GRANT_SOUTH});

endmodule

//--- flitSwitch.sv
`timescale 1ns/1ps
`include "nocRouterPort_macros.svh"

module flitSwitch
(
  input  logic                                 grantValid,
  input  nocPkg::portId_e                      grantPort,
  input  logic [`NUM_PORTS-1:0]                fifoValid,
  input  nocPkg::flit_t [`NUM_PORTS-1:0]       fifoFlit,
  output logic [`NUM_PORTS-1:0]                fifoPop,
  output logic                                 outValid,
  output nocPkg::outFlit_t                     outFlit,
  input  logic                                 outReady
);

  logic headValid;

  assign headValid = fifoValid[grantPort];

  // the head of the granted FIFO goes out tagged with its source.
  always_comb
  begin
    outFlit.src = grantPort;
    outFlit.flit = fifoFlit[grantPort];
  end

  always_comb
  begin
    fifoPop = '0;
    outValid = 1'b0;
    if (grantValid)
    begin
      outValid = headValid;
      // the head leaves its FIFO only once the output takes it.
      fifoPop[grantPort] = headValid && outReady;
    end
  end

endmodule

//--- routerOutputPort.sv
`timescale 1ns/1ps
`include "nocRouterPort_macros.svh"

module routerOutputPort
(
  input  logic                           clk,
  input  logic                           rst,
  input  logic [`NUM_PORTS-1:0]          inValid,
  input  nocPkg::flit_t [`NUM_PORTS-1:0] inFlit,
  output logic [`NUM_PORTS-1:0]          inReady,
  output logic                           outValid,
  output nocPkg::outFlit_t               outFlit,
  input  logic                           outReady
);

  logic [`NUM_PORTS-1:0]          fifoValid;
  nocPkg::flit_t [`NUM_PORTS-1:0] fifoFlit;
  logic [`NUM_PORTS-1:0]          fifoPop;
  logic                           grantValid;
  nocPkg::portId_e                grantPort;
  logic                           accepted;

  assign accepted = outValid && outReady;

  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : genFifo
    inputFifo fifo
    (
      .clk      (clk),
      .rst      (rst),
      .inValid  (inValid[i]),
      .inFlit   (inFlit[i]),
      .inReady  (inReady[i]),
      .outValid (fifoValid[i]),
      .outFlit  (fifoFlit[i]),
      .pop      (fifoPop[i])
    );
  end

  outputArbiter arbiter
  (
    .clk          (clk),
    .rst          (rst),
    .req          (fifoValid),
    .accepted     (accepted),
    .acceptedFlit (outFlit.flit),
    .grantValid   (grantValid),
    .grantPort    (grantPort)
  );

  flitSwitch switcher
  (
    .grantValid (grantValid),
    .grantPort  (grantPort),
    .fifoValid  (fifoValid),
    .fifoFlit   (fifoFlit),
    .fifoPop    (fifoPop),
    .outValid   (outValid),
    .outFlit    (outFlit),
    .outReady   (outReady)
  );

endmodule

//--- tb_routerOutputPort.sv
`timescale 1ns/1ps
`include "nocRouterPort_macros.svh"

module tb_routerOutputPort;

  logic                           clk;
  logic                           rst;
  logic [`NUM_PORTS-1:0]          inValid;
  nocPkg::flit_t [`NUM_PORTS-1:0] inFlit;
  logic [`NUM_PORTS-1:0]          inReady;
  logic                           outValid;
  nocPkg::outFlit_t               outFlit;
  logic                           outReady;

  int                    seed = 32'h3c8c;
  nocPkg::flit_t         sendQ [`NUM_PORTS][$];
  nocPkg::flit_t         expQ [`NUM_PORTS][$];
  logic [`NUM_PORTS-1:0] sent;
  int                    totalFlits = 0;
  int                    cycleCount = 0;
  logic                  randomReady;
  logic                  rrCheck;
  logic                  atomicCheck;
  logic                  predValid;
  int                    predSrc;
  int                    lastSrc;
  int                    winLen;
  logic                  winExpired;
  int                    budgetOf [`NUM_PORTS];
  logic                  pktOpen;
  int                    pktSrc;
  logic                  stallSeen;
  nocPkg::outFlit_t      stalledFlit;

  routerOutputPort uut
  (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inFlit   (inFlit),
    .inReady  (inReady),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outReady (outReady)
  );

  always #50 clk = ~clk;

  function automatic int randRange(input int lo, input int hi);
    logic [31:0] r;
    r = $random(seed);
    randRange = lo + int'(r % 32'(hi - lo + 1));
  endfunction

  // pops the oldest flit that the given source sent and has not yet been seen.
  function automatic nocPkg::flit_t expectedNext(input int src);
    expectedNext = expQ[src].pop_front();
  endfunction

  function automatic logic flitsWaiting();
    flitsWaiting = 1'b0;
    for (int i = 0; i < `NUM_PORTS; i++)
      if (expQ[i].size() != 0)
        flitsWaiting = 1'b1;
  endfunction

  // the search runs backwards so the last hit is the first channel after the holder.
  function automatic int expectedGrant(input int holder, input logic leave);
    int idx;
    expectedGrant = holder;
    if (leave)
    begin
      for (int k = `NUM_PORTS; k >= 1; k--)
      begin
        idx = (holder + k) % `NUM_PORTS;
        if (expQ[idx].size() != 0)
          expectedGrant = idx;
      end
    end
  endfunction

  function automatic logic stillBusy(input logic includeOutput);
    stillBusy = (inValid != '0) || (includeOutput && flitsWaiting());
    for (int i = 0; i < `NUM_PORTS; i++)
      if (sendQ[i].size() != 0)
        stillBusy = 1'b1;
  endfunction

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    if (actual !== expected)
    begin
      $display("[ERROR] %0t ns: %s: got 'h%0h, expected 'h%0h", $time, what, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic addPacket(input int ch, input int len, input int budget);
    nocPkg::flit_t f;
    for (int k = 0; k < len; k++)
    begin
      if (len == 1)
        f.kind = nocPkg::SINGLE;
      else if (k == 0)
        f.kind = nocPkg::HEAD;
      else if (k == len - 1)
        f.kind = nocPkg::TAIL;
      else
        f.kind = nocPkg::BODY;
      if (k == 0)
        f.payload = `PAYLOAD_W'(budget);
      else
        f.payload = `PAYLOAD_W'(randRange(0, (1 << `PAYLOAD_W) - 1));
      sendQ[ch].push_back(f);
    end
    totalFlits += len;
  endtask

  task automatic addRandomPackets(input int ch, input int count, input logic preempt);
    int len;
    for (int p = 0; p < count; p++)
    begin
      len = preempt ? randRange(3, 8) : randRange(1, 8);
      addPacket(ch, len, preempt ? randRange(1, len - 1) : len);
    end
  endtask

  // the grant model only holds when the input FIFOs match the queues, so
  // rotation is checked on buffered phases.
  task automatic releaseAndDrain(input logic checkRotation);
    rrCheck = checkRotation;
    randomReady = 1'b1;
    while (stillBusy(1'b1))
      @(posedge clk);
    randomReady = 1'b0;
    rrCheck = 1'b0;
  endtask

  task automatic scoreFlit(input nocPkg::outFlit_t f);
    int   s;
    logic isHead;
    s = int'(f.src);
    isHead = (f.flit.kind == nocPkg::HEAD) || (f.flit.kind == nocPkg::SINGLE);
    checkValue(expQ[s].size() != 0, 1, "flit from a channel with nothing pending");
    checkValue(f.flit, expectedNext(s), "flit order or data");
    if (predValid)
      checkValue(s, predSrc, "source after arbitration");
    if (atomicCheck && pktOpen)
      checkValue(s, pktSrc, "source inside an open packet");
    // window of flits since the grant, the head or the last expiry.
    if (s != lastSrc || isHead || winExpired)
      winLen = 1;
    else
      winLen++;
    if (isHead)
      budgetOf[s] = int'(f.flit.payload);
    winExpired = (winLen == budgetOf[s]);
    pktOpen = (f.flit.kind == nocPkg::HEAD) || (pktOpen && f.flit.kind == nocPkg::BODY);
    pktSrc = s;
    lastSrc = s;
    predValid = rrCheck && flitsWaiting();
    predSrc = expectedGrant(s, winExpired || expQ[s].size() == 0);
  endtask

  always @(posedge clk)
  begin
    #1;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (sent[i])
        expQ[i].push_back(sendQ[i].pop_front());
      inValid[i] = (sendQ[i].size() != 0);
      if (inValid[i])
        inFlit[i] = sendQ[i][0];
    end
  end

  always @(posedge clk)
  begin : readyDrive
    logic [31:0] r;
    #1;
    r = $random(seed);
    outReady = randomReady && (r[1:0] != 2'b00);
  end

  // the comparator samples mid-cycle, where every output has settled.
  always @(negedge clk)
  begin
    sent = inValid & inReady;
    if (!rst)
    begin
      if (stallSeen)
      begin
        checkValue(outValid, 1, "outValid dropped during an output stall");
        checkValue(outFlit, stalledFlit, "outFlit changed during an output stall");
      end
      stallSeen = outValid && !outReady;
      stalledFlit = outFlit;
      if (outValid && outReady)
        scoreFlit(outFlit);
    end
  end

  always @(negedge clk)
  begin
    cycleCount++;
    if (cycleCount > 200 + 20 * totalFlits)
    begin
      $display("the run timed out after %0d cycles with flits still pending", cycleCount);
      $display("*** FAILED ***");
      $fatal(1, "watchdog expired");
    end
  end

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    inValid = '0;
    inFlit = '0;
    outReady = 1'b0;
    randomReady = 1'b0;
    rrCheck = 1'b0;
    atomicCheck = 1'b0;
    predValid = 1'b0;
    predSrc = 0;
    lastSrc = 0;
    winLen = 0;
    winExpired = 1'b0;
    pktOpen = 1'b0;
    pktSrc = 0;
    stallSeen = 1'b0;
    sent = '0;
    for (int i = 0; i < `NUM_PORTS; i++)
      budgetOf[i] = 0;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
    @(negedge clk);
    checkValue(outValid, 0, "outValid after reset");
    checkValue(inReady, {`NUM_PORTS{1'b1}}, "inReady after reset");

    // all channels load while the output is stalled and LOCAL fills its FIFO.
    @(posedge clk);
    atomicCheck = 1'b1;
    addPacket(0, 8, 8);
    addPacket(0, 8, 8);
    for (int ch = 1; ch < `NUM_PORTS; ch++)
      addRandomPackets(ch, 2, 1'b0);
    while (stillBusy(1'b0))
      @(posedge clk);
    @(negedge clk);
    checkValue(inReady[0], 0, "inReady of a full input FIFO");
    @(posedge clk);
    releaseAndDrain(1'b1);

    // budgets shorter than the packets force the grant to rotate mid-packet.
    atomicCheck = 1'b0;
    for (int ch = 0; ch < `NUM_PORTS; ch++)
      addRandomPackets(ch, 2, 1'b1);
    while (stillBusy(1'b0))
      @(posedge clk);
    releaseAndDrain(1'b1);

    // streaming traffic with back-to-back packets on every channel.
    atomicCheck = 1'b1;
    for (int ch = 0; ch < `NUM_PORTS; ch++)
      addRandomPackets(ch, 6, 1'b0);
    releaseAndDrain(1'b0);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- nocRouterPort.f
+incdir+.
nocPkg.sv
inputFifo.sv
holdTimer.sv
outputArbiter.sv
flitSwitch.sv
routerOutputPort.sv
tb_routerOutputPort.sv

//--- Makefile
TOP = tb_routerOutputPort

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module routerOutputPort -f nocRouterPort.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f nocRouterPort.f -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	grep -qF "*** PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
